/* logic/xif_cfg_pkg.sv */
// Sizing constants of the offload buffer
// Width types for ids, slots, occupancy and scalar operands
package xif_cfg_pkg;

	// Instruction id width on the extension interface
	localparam int unsigned ID_W = 4;

	// One id map entry per possible id
	localparam int unsigned ID_NUM = 2 ** ID_W;

	// Buffer slots, power of two only
	localparam int unsigned DEPTH = 4;

	// Slot index width
	localparam int unsigned SLOT_W = $clog2(DEPTH);

	// Scalar register width of the core
	localparam int unsigned XLEN = 32;

	// Instruction id as issued by the core
	typedef logic [ID_W-1:0] id_t;

	// Slot index, wraps modulo DEPTH
	typedef logic [SLOT_W-1:0] slot_t;

	// Occupancy count
	// Extra bit so a full buffer is representable
	typedef logic [SLOT_W:0] usage_t;

	// Scalar operand
	typedef logic [XLEN-1:0] xlen_t;

endpackage : xif_cfg_pkg

/* logic/xif_dispatch_stage.sv */
// Dispatch stage of the offload buffer
// One-entry output register toward the vector backend
`timescale 1ns/1ps

module xif_dispatch_stage
	import xif_cfg_pkg::*;
	import xif_instr_pkg::*;
(
	input  logic   clk_i,
	input  logic   rst_ni,
	// Head entry of the ring buffer
	input  logic   buf_valid_i,
	output logic   buf_ready_o,
	input  instr_t buf_instr_i,
	input  xlen_t  buf_rs1_i,
	input  xlen_t  buf_rs2_i,
	input  frm_e   buf_frm_i,
	// Vector backend
	output logic   vec_valid_o,
	input  logic   vec_ready_i,
	output instr_t vec_instr_o,
	output xlen_t  vec_rs1_o,
	output xlen_t  vec_rs2_o,
	output frm_e   vec_frm_o
);

	disp_state_e state_q, state_d;

	// Held instruction
	instr_t      instr_q;
	xlen_t       rs1_q;
	xlen_t       rs2_q;
	frm_e        frm_q;

	logic        pop;

	// Room when empty or when the backend takes the held one
	assign buf_ready_o = (state_q == DISP_EMPTY) || vec_ready_i;
	assign pop         = buf_valid_i && buf_ready_o;

	always_comb begin
		state_d = state_q;
		case (state_q)
			DISP_EMPTY: begin
				if (pop) begin
					state_d = DISP_FULL;
				end
			end
			DISP_FULL: begin
				// A pop in the same cycle refills the register
				if (vec_ready_i && !pop) begin
					state_d = DISP_EMPTY;
				end
			end
			default: state_d = DISP_EMPTY;
		endcase
	end

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			state_q <= DISP_EMPTY;
		end else begin
			state_q <= state_d;
		end
	end

	// Payload loads on every pop
	always_ff @(posedge clk_i) begin
		if (pop) begin
			instr_q <= buf_instr_i;
			rs1_q   <= buf_rs1_i;
			rs2_q   <= buf_rs2_i;
			frm_q   <= buf_frm_i;
		end
	end

	assign vec_valid_o = (state_q == DISP_FULL);
	assign vec_instr_o = instr_q;
	assign vec_rs1_o   = rs1_q;
	assign vec_rs2_o   = rs2_q;
	assign vec_frm_o   = frm_q;

endmodule : xif_dispatch_stage

/* logic/xif_instr_pkg.sv */
// Instruction word field types and decode constants
// Rounding mode encoding and dispatch FSM states
package xif_instr_pkg;

	// Raw 32-bit instruction word
	typedef logic [31:0] instr_t;

	// Register file address
	typedef logic [4:0] reg_addr_t;

	// Operand valid flags
	// Bit 0 for rs1, bit 1 for rs2
	typedef logic [1:0] rs_valid_t;

	// Floating-point rounding mode
	typedef enum logic [2:0] {
		RNE = 3'b000,
		RTZ = 3'b001,
		RDN = 3'b010,
		RUP = 3'b011,
		RMM = 3'b100,
		DYN = 3'b111
	} frm_e;

	// Major opcode of all vector arithmetic
	localparam logic [6:0] OPC_OP_V = 7'b1010111;

	// funct3 of the integer and float vector-vector groups
	localparam logic [2:0] F3_OPMVV = 3'b010;
	localparam logic [2:0] F3_OPFVV = 3'b001;

	// funct6 of the moves from vector to scalar register
	// Covers vmv.x.s, vcpop, vfirst and vfmv.f.s
	localparam logic [5:0] F6_WXUNARY = 6'b010000;

	// Dispatch output register state
	typedef enum logic {
		DISP_EMPTY,
		DISP_FULL
	} disp_state_e;

endpackage : xif_instr_pkg

/* logic/xif_issue_stage.sv */
// Issue stage of the offload buffer
// Registers offloaded instructions and decodes the writeback flag
`timescale 1ns/1ps

module xif_issue_stage
	import xif_cfg_pkg::*;
	import xif_instr_pkg::*;
(
	input  logic   clk_i,
	input  logic   rst_ni,
	// Offload strobe from the core
	input  logic   issue_valid_i,
	input  id_t    issue_id_i,
	input  instr_t issue_instr_i,
	// Push toward the ring buffer
	output logic   push_o,
	output id_t    push_id_o,
	output instr_t push_instr_o,
	output logic   push_is_wb_o
);

	// Decoded fields
	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [5:0] funct6;
	logic       is_wb;

	// Pipeline registers
	logic       push_q;
	id_t        push_id_q;
	instr_t     push_instr_q;
	logic       push_is_wb_q;

	// Field extraction
	assign opcode = issue_instr_i[6:0];
	assign funct3 = issue_instr_i[14:12];
	assign funct6 = issue_instr_i[31:26];

	// Only the scalar-move group writes back to the core
	assign is_wb = (opcode == OPC_OP_V) &&
		((funct3 == F3_OPMVV) || (funct3 == F3_OPFVV)) &&
		(funct6 == F6_WXUNARY);

	// Push strobe lasts exactly one cycle
	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			push_q <= 1'b0;
		end else begin
			push_q <= issue_valid_i;
		end
	end

	// Payload only captured on a strobe
	always_ff @(posedge clk_i) begin
		if (issue_valid_i) begin
			push_id_q    <= issue_id_i;
			push_instr_q <= issue_instr_i;
			push_is_wb_q <= is_wb;
		end
	end

	assign push_o       = push_q;
	assign push_id_o    = push_id_q;
	assign push_instr_o = push_instr_q;
	assign push_is_wb_o = push_is_wb_q;

endmodule : xif_issue_stage

/* logic/xif_offload_top.sv */
// Offload buffer top level
// Issue stage, ring buffer and dispatch stage in a chain
`timescale 1ns/1ps

module xif_offload_top
	import xif_cfg_pkg::*;
	import xif_instr_pkg::*;
(
	input  logic      clk_i,
	input  logic      rst_ni,
	// Issue
	input  logic      issue_valid_i,
	input  id_t       issue_id_i,
	input  instr_t    issue_instr_i,
	output logic      issue_full_o,
	// Register operands
	input  logic      reg_valid_i,
	input  id_t       reg_id_i,
	input  xlen_t     rs1_i,
	input  xlen_t     rs2_i,
	input  rs_valid_t rs_valid_i,
	input  frm_e      frm_i,
	// Commit and flush
	input  logic      commit_valid_i,
	input  id_t       commit_id_i,
	input  logic      flush_i,
	input  id_t       flush_id_i,
	// Destination lookup
	input  logic      rd_req_i,
	input  id_t       rd_id_i,
	output reg_addr_t rd_o,
	output logic      we_o,
	// Vector backend
	output logic      vec_valid_o,
	input  logic      vec_ready_i,
	output instr_t    vec_instr_o,
	output xlen_t     vec_rs1_o,
	output xlen_t     vec_rs2_o,
	output frm_e      vec_frm_o
);

	// Issue stage to buffer
	logic   push;
	id_t    push_id;
	instr_t push_instr;
	logic   push_is_wb;

	// Buffer to dispatch
	logic   buf_valid;
	logic   buf_ready;
	instr_t buf_instr;
	xlen_t  buf_rs1;
	xlen_t  buf_rs2;
	frm_e   buf_frm;

	xif_issue_stage i_issue (
		.clk_i         (clk_i),
		.rst_ni        (rst_ni),
		.issue_valid_i (issue_valid_i),
		.issue_id_i    (issue_id_i),
		.issue_instr_i (issue_instr_i),
		.push_o        (push),
		.push_id_o     (push_id),
		.push_instr_o  (push_instr),
		.push_is_wb_o  (push_is_wb)
	);

	// Buffer full level goes straight back to the core
	xif_ring_buffer i_buffer (
		.clk_i          (clk_i),
		.rst_ni         (rst_ni),
		.push_i         (push),
		.push_id_i      (push_id),
		.push_instr_i   (push_instr),
		.push_is_wb_i   (push_is_wb),
		.reg_valid_i    (reg_valid_i),
		.reg_id_i       (reg_id_i),
		.rs1_i          (rs1_i),
		.rs2_i          (rs2_i),
		.rs_valid_i     (rs_valid_i),
		.frm_i          (frm_i),
		.commit_valid_i (commit_valid_i),
		.commit_id_i    (commit_id_i),
		.flush_i        (flush_i),
		.flush_id_i     (flush_id_i),
		.rd_req_i       (rd_req_i),
		.rd_id_i        (rd_id_i),
		.rd_o           (rd_o),
		.we_o           (we_o),
		.full_o         (issue_full_o),
		.valid_o        (buf_valid),
		.ready_i        (buf_ready),
		.instr_o        (buf_instr),
		.rs1_o          (buf_rs1),
		.rs2_o          (buf_rs2),
		.frm_o          (buf_frm)
	);

	xif_dispatch_stage i_dispatch (
		.clk_i       (clk_i),
		.rst_ni      (rst_ni),
		.buf_valid_i (buf_valid),
		.buf_ready_o (buf_ready),
		.buf_instr_i (buf_instr),
		.buf_rs1_i   (buf_rs1),
		.buf_rs2_i   (buf_rs2),
		.buf_frm_i   (buf_frm),
		.vec_valid_o (vec_valid_o),
		.vec_ready_i (vec_ready_i),
		.vec_instr_o (vec_instr_o),
		.vec_rs1_o   (vec_rs1_o),
		.vec_rs2_o   (vec_rs2_o),
		.vec_frm_o   (vec_frm_o)
	);

endmodule : xif_offload_top

/* logic/xif_ring_buffer.sv */
// Ring buffer of offloaded vector instructions
// Slot storage with id map, operand fill, commit, flush and rd lookup
`timescale 1ns/1ps

module xif_ring_buffer
	import xif_cfg_pkg::*;
	import xif_instr_pkg::*;
(
	input  logic      clk_i,
	input  logic      rst_ni,
	// Push from the issue stage
	input  logic      push_i,
	input  id_t       push_id_i,
	input  instr_t    push_instr_i,
	input  logic      push_is_wb_i,
	// Scalar operands by id
	input  logic      reg_valid_i,
	input  id_t       reg_id_i,
	input  xlen_t     rs1_i,
	input  xlen_t     rs2_i,
	input  rs_valid_t rs_valid_i,
	input  frm_e      frm_i,
	// Commit and flush by id
	input  logic      commit_valid_i,
	input  id_t       commit_id_i,
	input  logic      flush_i,
	input  id_t       flush_id_i,
	// Destination lookup
	input  logic      rd_req_i,
	input  id_t       rd_id_i,
	output reg_addr_t rd_o,
	output logic      we_o,
	// Occupancy
	output logic      full_o,
	// Head entry toward dispatch
	output logic      valid_o,
	input  logic      ready_i,
	output instr_t    instr_o,
	output xlen_t     rs1_o,
	output xlen_t     rs2_o,
	output frm_e      frm_o
);

	// Slot storage
	instr_t    instr_q    [DEPTH];
	instr_t    instr_d    [DEPTH];
	xlen_t     rs1_q      [DEPTH];
	xlen_t     rs1_d      [DEPTH];
	xlen_t     rs2_q      [DEPTH];
	xlen_t     rs2_d      [DEPTH];
	frm_e      frm_q      [DEPTH];
	frm_e      frm_d      [DEPTH];
	rs_valid_t rs_valid_q [DEPTH];
	rs_valid_t rs_valid_d [DEPTH];
	logic      is_wb_q    [DEPTH];
	logic      is_wb_d    [DEPTH];
	// Id to slot map
	slot_t     id_map_q   [ID_NUM];
	slot_t     id_map_d   [ID_NUM];

	// Pointers and occupancy
	slot_t     head_q, head_d;
	slot_t     tail_q, tail_d;
	slot_t     commit_q, commit_d;
	usage_t    usage_q, usage_d;
	// Commit pointer has reached the tail
	// Tells a full committed buffer apart from an uncommitted head
	logic      all_cmt_q, all_cmt_d;

	logic      empty;
	logic      push_ok;
	logic      pop;
	logic      store_en;

	assign full_o  = (usage_q == usage_t'(DEPTH));
	assign empty   = (usage_q == '0);
	assign push_ok = push_i && !full_o;
	assign pop     = valid_o && ready_i;
	// Storage only clocked when something is written
	assign store_en = push_ok || reg_valid_i;

	// Head needs operands and must sit before the commit pointer
	assign valid_o = !empty && (rs_valid_q[head_q] != '0) &&
		(all_cmt_q || (head_q != commit_q));

	// Head entry
	assign instr_o = instr_q[head_q];
	assign rs1_o   = rs1_q[head_q];
	assign rs2_o   = rs2_q[head_q];
	assign frm_o   = frm_q[head_q];

	// Zero-cycle rd lookup
	assign rd_o = rd_req_i ? instr_q[id_map_q[rd_id_i]][11:7] : '0;
	assign we_o = rd_req_i && is_wb_q[id_map_q[rd_id_i]];

	always_comb begin
		instr_d    = instr_q;
		rs1_d      = rs1_q;
		rs2_d      = rs2_q;
		frm_d      = frm_q;
		rs_valid_d = rs_valid_q;
		is_wb_d    = is_wb_q;
		id_map_d   = id_map_q;
		head_d     = head_q;
		tail_d     = tail_q;
		commit_d   = commit_q;
		usage_d    = usage_q;
		all_cmt_d  = all_cmt_q;

		// New entry at the tail
		if (push_ok) begin
			instr_d[tail_q]     = push_instr_i;
			is_wb_d[tail_q]     = push_is_wb_i;
			// Operands of a previous occupant are stale
			rs_valid_d[tail_q]  = '0;
			id_map_d[push_id_i] = tail_q;
			tail_d              = tail_q + 1'b1;
			usage_d             = usage_q + 1'b1;
		end

		// Operands through the updated map
		// A push of the same id in this cycle is found as well
		if (reg_valid_i) begin
			rs1_d[id_map_d[reg_id_i]]      = rs1_i;
			rs2_d[id_map_d[reg_id_i]]      = rs2_i;
			rs_valid_d[id_map_d[reg_id_i]] = rs_valid_i;
			frm_d[id_map_d[reg_id_i]]      = frm_i;
		end

		// Commit pointer goes one past the committed id
		if (commit_valid_i) begin
			commit_d  = id_map_d[commit_id_i] + 1'b1;
			all_cmt_d = (commit_d == tail_d);
		end else if (push_ok) begin
			// Fresh entry is not committed yet
			all_cmt_d = 1'b0;
		end

		// Hand the head to dispatch
		if (pop) begin
			head_d  = head_q + 1'b1;
			usage_d = usage_d - 1'b1;
		end

		// Drop the flushed id and everything younger
		if (flush_i && !empty) begin
			tail_d    = id_map_q[flush_id_i];
			usage_d   = {1'b0, slot_t'(tail_d - head_d)};
			all_cmt_d = (commit_d == tail_d);
		end
	end

	// Pointers and occupancy
	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			head_q    <= '0;
			tail_q    <= '0;
			commit_q  <= '0;
			usage_q   <= '0;
			all_cmt_q <= 1'b0;
		end else begin
			head_q    <= head_d;
			tail_q    <= tail_d;
			commit_q  <= commit_d;
			usage_q   <= usage_d;
			all_cmt_q <= all_cmt_d;
		end
	end

	// Per-slot flags and the id map
	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			rs_valid_q <= '{default: '0};
			is_wb_q    <= '{default: 1'b0};
			id_map_q   <= '{default: '0};
		end else if (store_en) begin
			rs_valid_q <= rs_valid_d;
			is_wb_q    <= is_wb_d;
			id_map_q   <= id_map_d;
		end
	end

	// Instruction and operand payload
	always_ff @(posedge clk_i) begin
		if (store_en) begin
			instr_q <= instr_d;
			rs1_q   <= rs1_d;
			rs2_q   <= rs2_d;
			frm_q   <= frm_d;
		end
	end

endmodule : xif_ring_buffer

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_xif_offload -f xif_offload.f

out=$(./obj_dir/Vtb_xif_offload)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx 'Done: no errors'; then
	exit 0
fi
exit 1

/* tb/tb_xif_tasks.svh */
// Interface drivers and directed tests of the offload buffer
// Included into the testbench top module

// Vector arithmetic word, vm set, vs1 and rs1 zero
function automatic instr_t vec_op(input logic [5:0] funct6, input logic [2:0] funct3,
	input reg_addr_t rd, input reg_addr_t vs2);
	return {funct6, 1'b1, vs2, 5'd0, funct3, rd, OPC_OP_V};
endfunction

task automatic idle(input int unsigned n);
	repeat (n) @(posedge clk_i);
endtask

// One-cycle issue strobe
task automatic issue_instr(input id_t id, input instr_t instr);
	@(posedge clk_i);
	issue_valid_i <= 1'b1;
	issue_id_i    <= id;
	issue_instr_i <= instr;
	@(posedge clk_i);
	issue_valid_i <= 1'b0;
endtask

// Operands of one entry, both marked valid
task automatic write_entry(input id_t id, input entry_t e);
	@(posedge clk_i);
	reg_valid_i <= 1'b1;
	reg_id_i    <= id;
	rs1_i       <= e[66:35];
	rs2_i       <= e[34:3];
	rs_valid_i  <= 2'b11;
	frm_i       <= frm_e'(e[2:0]);
	@(posedge clk_i);
	reg_valid_i <= 1'b0;
endtask

task automatic commit_instr(input id_t id);
	@(posedge clk_i);
	commit_valid_i <= 1'b1;
	commit_id_i    <= id;
	@(posedge clk_i);
	commit_valid_i <= 1'b0;
endtask

// Discards this id and all younger ones
task automatic flush_from(input id_t id);
	@(posedge clk_i);
	flush_i    <= 1'b1;
	flush_id_i <= id;
	@(posedge clk_i);
	flush_i <= 1'b0;
endtask

// Combinational lookup, sampled one edge after the request
task automatic lookup_rd(input id_t id, input reg_addr_t rd, input logic we);
	@(posedge clk_i);
	rd_req_i <= 1'b1;
	rd_id_i  <= id;
	@(posedge clk_i);
	check_value($sformatf("rd of id %0d", id), rd, rd_o);
	check_value($sformatf("we of id %0d", id), we, we_o);
	rd_req_i <= 1'b0;
endtask

// Bounded wait for the scoreboard to empty
task automatic wait_drained(input int unsigned limit);
	int unsigned n;
	n = 0;
	while (exp_q.size() != 0 && n < limit) begin
		@(posedge clk_i);
		n++;
	end
	if (exp_q.size() != 0) begin
		errors++;
		$display("Error in %s: %0d expected instructions did not reach the backend in %0d cycles",
			test_name, exp_q.size(), limit);
		exp_q.delete();
	end
	// Leaves room for a stray extra dispatch to show up
	idle(4);
endtask

task automatic test_reset_state();
	test_name = "reset_state";
	idle(2);
	check_value("vec_valid_o", 0, vec_valid_o);
	check_value("issue_full_o", 0, issue_full_o);
	check_value("we_o", 0, we_o);
	// No stored entry, so no writeback even with a request
	@(posedge clk_i);
	rd_req_i <= 1'b1;
	rd_id_i  <= '0;
	@(posedge clk_i);
	check_value("we_o on lookup", 0, we_o);
	rd_req_i <= 1'b0;
endtask

task automatic test_in_order();
	entry_t e [3];
	test_name = "in_order";
	// vadd.vv, vmul.vv, vfadd.vv
	e[0] = random_entry(vec_op(6'b000000, 3'b000, 5'd1, 5'd2));
	e[1] = random_entry(vec_op(6'b100101, 3'b010, 5'd3, 5'd4));
	e[2] = random_entry(vec_op(6'b000000, 3'b001, 5'd5, 5'd6));
	issue_instr(4'd1, e[0][98:67]);
	issue_instr(4'd2, e[1][98:67]);
	issue_instr(4'd3, e[2][98:67]);
	// Operands out of issue order
	write_entry(4'd3, e[2]);
	write_entry(4'd1, e[0]);
	write_entry(4'd2, e[1]);
	exp_q.push_back(e[0]);
	exp_q.push_back(e[1]);
	exp_q.push_back(e[2]);
	commit_instr(4'd3);
	wait_drained(40);
endtask

task automatic test_gating();
	entry_t a;
	entry_t b;
	entry_t c;
	test_name = "gating";
	a = random_entry(vec_op(6'b000010, 3'b000, 5'd7, 5'd8));
	b = random_entry(vec_op(6'b001001, 3'b000, 5'd9, 5'd10));
	c = random_entry(vec_op(6'b001010, 3'b000, 5'd11, 5'd12));
	issue_instr(4'd4, a[98:67]);
	issue_instr(4'd5, b[98:67]);
	// Younger one complete, head still without operands
	write_entry(4'd5, b);
	commit_instr(4'd5);
	idle(10);
	check_value("valid without head operands", 0, vec_valid_o);
	exp_q.push_back(a);
	exp_q.push_back(b);
	write_entry(4'd4, a);
	wait_drained(30);
	// Operands present, commit missing
	issue_instr(4'd6, c[98:67]);
	write_entry(4'd6, c);
	idle(10);
	check_value("valid before commit", 0, vec_valid_o);
	exp_q.push_back(c);
	commit_instr(4'd6);
	wait_drained(30);
endtask

task automatic test_rd_lookup();
	entry_t e [3];
	test_name = "rd_lookup";
	// vmv.x.s, vfmv.f.s, vadd.vv
	e[0] = random_entry(vec_op(6'b010000, 3'b010, 5'd9, 5'd3));
	e[1] = random_entry(vec_op(6'b010000, 3'b001, 5'd14, 5'd4));
	e[2] = random_entry(vec_op(6'b000000, 3'b000, 5'd27, 5'd5));
	issue_instr(4'd7, e[0][98:67]);
	issue_instr(4'd8, e[1][98:67]);
	issue_instr(4'd9, e[2][98:67]);
	idle(1);
	lookup_rd(4'd7, 5'd9, 1'b1);
	lookup_rd(4'd8, 5'd14, 1'b1);
	lookup_rd(4'd9, 5'd27, 1'b0);
	// Drain so later tests start from an empty buffer
	write_entry(4'd7, e[0]);
	write_entry(4'd8, e[1]);
	write_entry(4'd9, e[2]);
	exp_q.push_back(e[0]);
	exp_q.push_back(e[1]);
	exp_q.push_back(e[2]);
	commit_instr(4'd9);
	wait_drained(40);
endtask

task automatic test_flush();
	entry_t      e [6];
	int unsigned i;
	test_name = "flush";
	for (i = 0; i < 4; i++) begin
		e[i] = random_entry(vec_op(6'b000000, 3'b000, 5'(i + 1), 5'd1));
		issue_instr(id_t'(i + 1), e[i][98:67]);
	end
	for (i = 0; i < 4; i++) begin
		write_entry(id_t'(i + 1), e[i]);
	end
	// Ids 3 and 4 go away
	flush_from(4'd3);
	e[4] = random_entry(vec_op(6'b000010, 3'b000, 5'd21, 5'd2));
	e[5] = random_entry(vec_op(6'b000010, 3'b000, 5'd22, 5'd2));
	issue_instr(4'd10, e[4][98:67]);
	issue_instr(4'd11, e[5][98:67]);
	write_entry(4'd10, e[4]);
	write_entry(4'd11, e[5]);
	idle(2);
	check_value("full after refill", 1, issue_full_o);
	exp_q.push_back(e[0]);
	exp_q.push_back(e[1]);
	exp_q.push_back(e[4]);
	exp_q.push_back(e[5]);
	commit_instr(4'd11);
	wait_drained(40);
endtask

task automatic test_back_pressure();
	entry_t      e;
	int unsigned i;
	int unsigned n;
	test_name = "back_pressure";
	@(posedge clk_i);
	vec_ready_i <= 1'b0;
	// First one parks in the dispatch register, the rest fill the buffer
	for (i = 0; i <= DEPTH; i++) begin
		e = random_entry(vec_op(6'b000000, 3'b000, 5'(i + 16), 5'd2));
		issue_instr(id_t'(i + 11), e[98:67]);
		write_entry(id_t'(i + 11), e);
		exp_q.push_back(e);
		commit_instr(id_t'(i + 11));
		idle(2);
		check_value($sformatf("full after entry %0d", i), (i == DEPTH), issue_full_o);
	end
	check_value("held output", 1, vec_valid_o);
	// Random ready pattern until the backlog is gone
	n = 0;
	while (exp_q.size() != 0 && n < 200) begin
		@(posedge clk_i);
		vec_ready_i <= (random_bits(1) != 0);
		n++;
	end
	@(posedge clk_i);
	vec_ready_i <= 1'b1;
	wait_drained(20);
	check_value("full after drain", 0, issue_full_o);
endtask

/* tb/tb_xif_offload.sv */
// Testbench top of the offload buffer
// Clock, reset, DUT, dispatch monitor, watchdog, LFSR and check task
`timescale 1ns/1ps

module tb_xif_offload
	import xif_cfg_pkg::*;
	import xif_instr_pkg::*;
();

	// Packed dispatch record of instr, rs1, rs2 and frm
	typedef logic [98:0] entry_t;

	// Cycle budget of each test
	localparam int unsigned CYC_RESET         = 16;
	localparam int unsigned CYC_RESET_STATE   = 10;
	localparam int unsigned CYC_IN_ORDER      = 80;
	localparam int unsigned CYC_GATING        = 120;
	localparam int unsigned CYC_RD_LOOKUP     = 90;
	localparam int unsigned CYC_FLUSH         = 110;
	localparam int unsigned CYC_BACK_PRESSURE = 300;
	localparam int unsigned RUN_CYCLES = CYC_RESET + CYC_RESET_STATE + CYC_IN_ORDER +
		CYC_GATING + CYC_RD_LOOKUP + CYC_FLUSH + CYC_BACK_PRESSURE;
	// Twice the expected length at 4 ns per cycle
	localparam int unsigned TIMEOUT_NS = 2 * RUN_CYCLES * 4;

	logic      clk_i;
	logic      rst_ni;
	logic      issue_valid_i;
	id_t       issue_id_i;
	instr_t    issue_instr_i;
	logic      issue_full_o;
	logic      reg_valid_i;
	id_t       reg_id_i;
	xlen_t     rs1_i;
	xlen_t     rs2_i;
	rs_valid_t rs_valid_i;
	frm_e      frm_i;
	logic      commit_valid_i;
	id_t       commit_id_i;
	logic      flush_i;
	id_t       flush_id_i;
	logic      rd_req_i;
	id_t       rd_id_i;
	reg_addr_t rd_o;
	logic      we_o;
	logic      vec_valid_o;
	logic      vec_ready_i;
	instr_t    vec_instr_o;
	xlen_t     vec_rs1_o;
	xlen_t     vec_rs2_o;
	frm_e      vec_frm_o;

	// Scoreboard of dispatches still to come with the oldest first
	entry_t      exp_q [$];
	entry_t      exp_head;
	string       test_name = "reset";
	int unsigned checks = 0;
	int unsigned errors = 0;
	logic [31:0] lfsr_state = 32'h388aed2a;

	xif_offload_top dut (.*);

	initial begin
		clk_i = 1'b0;
		forever #2 clk_i = ~clk_i;
	end

	// Galois LFSR stepped once per bit taken
	function automatic logic [31:0] random_bits(input int unsigned n);
		logic [31:0] val;
		int unsigned i;
		val = '0;
		for (i = 0; i < n; i++) begin
			lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h80200003) : (lfsr_state >> 1);
			val = {val[30:0], lfsr_state[0]};
		end
		return val;
	endfunction

	// Random operands around a given instruction
	function automatic entry_t random_entry(input instr_t instr);
		xlen_t      a;
		xlen_t      b;
		logic [1:0] f;
		a = random_bits(32);
		b = random_bits(32);
		// RNE to RUP only
		f = 2'(random_bits(2));
		return {instr, a, b, 1'b0, f};
	endfunction

	task automatic check_value(input string what, input logic [127:0] expected,
		input logic [127:0] actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("Mismatch in %s, %s: expected %0h, actual %0h",
				test_name, what, expected, actual);
		end
	endtask

	`include "tb_xif_tasks.svh"

	// Every backend handshake must match the oldest expectation
	always @(posedge clk_i) begin
		if (rst_ni && vec_valid_o && vec_ready_i) begin
			if (exp_q.size() == 0) begin
				errors++;
				$display("Error in %s: the backend received an instruction that was not expected",
					test_name);
			end else begin
				exp_head = exp_q.pop_front();
				check_value("dispatched entry", exp_head,
					{vec_instr_o, vec_rs1_o, vec_rs2_o, vec_frm_o});
			end
		end
	end

	// Watchdog
	initial begin
		#(TIMEOUT_NS);
		$display("Timeout after %0d ns in %s, the test sequence did not finish",
			TIMEOUT_NS, test_name);
		$display("Done: errors found");
		$finish;
	end

	initial begin
		rst_ni         = 1'b0;
		issue_valid_i  = 1'b0;
		issue_id_i     = '0;
		issue_instr_i  = '0;
		reg_valid_i    = 1'b0;
		reg_id_i       = '0;
		rs1_i          = '0;
		rs2_i          = '0;
		rs_valid_i     = '0;
		frm_i          = RNE;
		commit_valid_i = 1'b0;
		commit_id_i    = '0;
		flush_i        = 1'b0;
		flush_id_i     = '0;
		rd_req_i       = 1'b0;
		rd_id_i        = '0;
		vec_ready_i    = 1'b1;
		repeat (CYC_RESET) @(posedge clk_i);
		rst_ni <= 1'b1;

		test_reset_state();
		test_in_order();
		test_gating();
		test_rd_lookup();
		test_flush();
		test_back_pressure();

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule : tb_xif_offload

/* xif_offload.f */
+incdir+tb
logic/xif_cfg_pkg.sv
logic/xif_instr_pkg.sv
logic/xif_issue_stage.sv
logic/xif_ring_buffer.sv
logic/xif_dispatch_stage.sv
logic/xif_offload_top.sv
tb/tb_xif_offload.sv
